// ==== Bender.yml ====
package:
  name: cache_subsys

sources:
  - cache_pkg.sv
  - cache_way_store.sv
  - icache.sv
  - dcache.sv
  - mem_arbiter.sv
  - cache_subsys_top.sv
  - target: test
    files:
      - tb_cache_subsys.sv

// ==== cache_pkg.sv ====
// shared widths, memory and core request structs and FSM enums, imported by every cache module
package cache_pkg;

    // byte address and line word widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;

    // request from a cache towards the memory port
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                we;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] strb;
    } mem_req_t;

    // memory reply, ack is a single-cycle pulse
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    // core data request, same layout as mem_req_t
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                we;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] strb;
    } dc_req_t;

    // controller states, WRITE_MEM is only reached by the data cache
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        WRITE_MEM,
        RESP
    } cache_state_e;

    typedef enum logic {
        WAY0,
        WAY1
    } way_sel_e;

endpackage

// ==== cache_subsys.f ====
cache_pkg.sv
cache_way_store.sv
icache.sv
dcache.sv
mem_arbiter.sv
cache_subsys_top.sv
tb_cache_subsys.sv

// ==== cache_subsys_top.sv ====
// top level of the memory front end, joins both caches, their way stores and the arbiter
`timescale 1ns/1ps
module cache_subsys_top #(
    parameter int INDEX_W = 6
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_if_req,
    input  logic [cache_pkg::ADDR_W-1:0] i_if_addr,
    output logic                         o_if_busy,
    output logic                         o_if_valid,
    output logic [31:0]                  o_if_data,
    input  logic                         i_dc_req,
    input  cache_pkg::dc_req_t           i_dc_cmd,
    output logic                         o_dc_busy,
    output logic                         o_dc_valid,
    output logic [cache_pkg::DATA_W-1:0] o_dc_rdata,
    output logic                         o_mem_valid,
    output cache_pkg::mem_req_t          o_mem_req,
    input  cache_pkg::mem_rsp_t          i_mem_rsp
);
    import cache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - 3;

    // instruction side
    logic                ic_rd_en, ic_wr_en, ic_wr_fill, ic_lru_en, ic_vld0, ic_vld1, ic_rq;
    logic [INDEX_W-1:0]  ic_index;
    logic [TAG_W-1:0]    ic_wr_tag, ic_tag0, ic_tag1;
    logic [DATA_W-1:0]   ic_wr_data, ic_data0, ic_data1;
    logic [DATA_W/8-1:0] ic_wr_strb;
    way_sel_e            ic_wr_way, ic_lru_way, ic_lru;
    mem_req_t            ic_mreq;
    mem_rsp_t            ic_mrsp;

    // data side
    logic                dc_rd_en, dc_wr_en, dc_wr_fill, dc_lru_en, dc_vld0, dc_vld1, dc_rq;
    logic [INDEX_W-1:0]  dc_index;
    logic [TAG_W-1:0]    dc_wr_tag, dc_tag0, dc_tag1;
    logic [DATA_W-1:0]   dc_wr_data, dc_data0, dc_data1;
    logic [DATA_W/8-1:0] dc_wr_strb;
    way_sel_e            dc_wr_way, dc_lru_way, dc_lru;
    mem_req_t            dc_mreq;
    mem_rsp_t            dc_mrsp;

    icache #(.INDEX_W(INDEX_W)) u_icache (
        .clk(clk), .rst(rst), .i_if_req(i_if_req), .i_if_addr(i_if_addr),
        .o_if_busy(o_if_busy), .o_if_valid(o_if_valid), .o_if_data(o_if_data),
        .o_mem_req(ic_mreq), .o_mem_rq(ic_rq), .i_mem_rsp(ic_mrsp),
        .o_rd_en(ic_rd_en), .o_index(ic_index), .o_wr_en(ic_wr_en), .o_wr_way(ic_wr_way),
        .o_wr_tag(ic_wr_tag), .o_wr_data(ic_wr_data), .o_wr_strb(ic_wr_strb),
        .o_wr_fill(ic_wr_fill), .o_lru_en(ic_lru_en), .o_lru_way(ic_lru_way),
        .i_tag0(ic_tag0), .i_tag1(ic_tag1), .i_vld0(ic_vld0), .i_vld1(ic_vld1),
        .i_data0(ic_data0), .i_data1(ic_data1), .i_lru(ic_lru)
    );

    cache_way_store #(.INDEX_W(INDEX_W)) u_ic_store (
        .clk(clk), .rst(rst), .i_rd_en(ic_rd_en), .i_index(ic_index),
        .i_wr_en(ic_wr_en), .i_wr_way(ic_wr_way), .i_wr_tag(ic_wr_tag),
        .i_wr_data(ic_wr_data), .i_wr_strb(ic_wr_strb), .i_wr_fill(ic_wr_fill),
        .i_lru_en(ic_lru_en), .i_lru_way(ic_lru_way),
        .o_tag0(ic_tag0), .o_tag1(ic_tag1), .o_vld0(ic_vld0), .o_vld1(ic_vld1),
        .o_data0(ic_data0), .o_data1(ic_data1), .o_lru(ic_lru)
    );

    dcache #(.INDEX_W(INDEX_W)) u_dcache (
        .clk(clk), .rst(rst), .i_dc_req(i_dc_req), .i_dc_cmd(i_dc_cmd),
        .o_dc_busy(o_dc_busy), .o_dc_valid(o_dc_valid), .o_dc_rdata(o_dc_rdata),
        .o_mem_req(dc_mreq), .o_mem_rq(dc_rq), .i_mem_rsp(dc_mrsp),
        .o_rd_en(dc_rd_en), .o_index(dc_index), .o_wr_en(dc_wr_en), .o_wr_way(dc_wr_way),
        .o_wr_tag(dc_wr_tag), .o_wr_data(dc_wr_data), .o_wr_strb(dc_wr_strb),
        .o_wr_fill(dc_wr_fill), .o_lru_en(dc_lru_en), .o_lru_way(dc_lru_way),
        .i_tag0(dc_tag0), .i_tag1(dc_tag1), .i_vld0(dc_vld0), .i_vld1(dc_vld1),
        .i_data0(dc_data0), .i_data1(dc_data1), .i_lru(dc_lru)
    );

    cache_way_store #(.INDEX_W(INDEX_W)) u_dc_store (
        .clk(clk), .rst(rst), .i_rd_en(dc_rd_en), .i_index(dc_index),
        .i_wr_en(dc_wr_en), .i_wr_way(dc_wr_way), .i_wr_tag(dc_wr_tag),
        .i_wr_data(dc_wr_data), .i_wr_strb(dc_wr_strb), .i_wr_fill(dc_wr_fill),
        .i_lru_en(dc_lru_en), .i_lru_way(dc_lru_way),
        .o_tag0(dc_tag0), .o_tag1(dc_tag1), .o_vld0(dc_vld0), .o_vld1(dc_vld1),
        .o_data0(dc_data0), .o_data1(dc_data1), .o_lru(dc_lru)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .i_ic_rq(ic_rq), .i_ic_req(ic_mreq), .o_ic_rsp(ic_mrsp),
        .i_dc_rq(dc_rq), .i_dc_req(dc_mreq), .o_dc_rsp(dc_mrsp),
        .o_mem_valid(o_mem_valid), .o_mem_req(o_mem_req), .i_mem_rsp(i_mem_rsp)
    );

endmodule

// ==== cache_way_store.sv ====
// tag, valid and data arrays of a two-way cache with one LRU bit per set, driven by one controller
`timescale 1ns/1ps
module cache_way_store #(
    parameter int  INDEX_W = 6,
    localparam int TAG_W   = cache_pkg::ADDR_W - INDEX_W - 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_rd_en,
    input  logic [INDEX_W-1:0]             i_index,
    input  logic                           i_wr_en,
    input  cache_pkg::way_sel_e            i_wr_way,
    input  logic [TAG_W-1:0]               i_wr_tag,
    input  logic [cache_pkg::DATA_W-1:0]   i_wr_data,
    input  logic [cache_pkg::DATA_W/8-1:0] i_wr_strb,
    input  logic                           i_wr_fill,
    input  logic                           i_lru_en,
    input  cache_pkg::way_sel_e            i_lru_way,
    output logic [TAG_W-1:0]               o_tag0,
    output logic [TAG_W-1:0]               o_tag1,
    output logic                           o_vld0,
    output logic                           o_vld1,
    output logic [cache_pkg::DATA_W-1:0]   o_data0,
    output logic [cache_pkg::DATA_W-1:0]   o_data1,
    output cache_pkg::way_sel_e            o_lru
);
    import cache_pkg::*;

    localparam int SETS = 2 ** INDEX_W;

    logic [TAG_W-1:0]  tag_mem  [2][SETS];
    logic [DATA_W-1:0] data_mem [2][SETS];
    logic [1:0][SETS-1:0] vld_q;
    // set bit means way 1 is the next victim
    logic [SETS-1:0]   lru_q;

    // synchronous arrays, read data appears the cycle after i_rd_en
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            if (i_wr_fill)
                tag_mem[i_wr_way][i_index] <= i_wr_tag;
            // a fill replaces the whole word, a store hit only its strobed bytes
            for (int b = 0; b < DATA_W / 8; b++) begin
                if (i_wr_fill || i_wr_strb[b])
                    data_mem[i_wr_way][i_index][8*b +: 8] <= i_wr_data[8*b +: 8];
            end
        end
        if (i_rd_en) begin
            o_tag0  <= tag_mem[0][i_index];
            o_tag1  <= tag_mem[1][i_index];
            o_data0 <= data_mem[0][i_index];
            o_data1 <= data_mem[1][i_index];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vld_q  <= '0;
            lru_q  <= '0;
            o_vld0 <= 1'b0;
            o_vld1 <= 1'b0;
            o_lru  <= WAY0;
        end else begin
            if (i_wr_en && i_wr_fill)
                vld_q[i_wr_way][i_index] <= 1'b1;
            // victim is the way not used last
            if (i_lru_en)
                lru_q[i_index] <= (i_lru_way == WAY0);
            if (i_rd_en) begin
                o_vld0 <= vld_q[0][i_index];
                o_vld1 <= vld_q[1][i_index];
                o_lru  <= way_sel_e'(lru_q[i_index]);
            end
        end
    end

endmodule

// ==== dcache.sv ====
// data cache controller, load lookup with refill and write-through stores without allocation
`timescale 1ns/1ps
module dcache #(
    parameter int  INDEX_W = 6,
    localparam int TAG_W   = cache_pkg::ADDR_W - INDEX_W - 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_dc_req,
    input  cache_pkg::dc_req_t             i_dc_cmd,
    output logic                           o_dc_busy,
    output logic                           o_dc_valid,
    output logic [cache_pkg::DATA_W-1:0]   o_dc_rdata,
    output cache_pkg::mem_req_t            o_mem_req,
    output logic                           o_mem_rq,
    input  cache_pkg::mem_rsp_t            i_mem_rsp,
    output logic                           o_rd_en,
    output logic [INDEX_W-1:0]             o_index,
    output logic                           o_wr_en,
    output cache_pkg::way_sel_e            o_wr_way,
    output logic [TAG_W-1:0]               o_wr_tag,
    output logic [cache_pkg::DATA_W-1:0]   o_wr_data,
    output logic [cache_pkg::DATA_W/8-1:0] o_wr_strb,
    output logic                           o_wr_fill,
    output logic                           o_lru_en,
    output cache_pkg::way_sel_e            o_lru_way,
    input  logic [TAG_W-1:0]               i_tag0,
    input  logic [TAG_W-1:0]               i_tag1,
    input  logic                           i_vld0,
    input  logic                           i_vld1,
    input  logic [cache_pkg::DATA_W-1:0]   i_data0,
    input  logic [cache_pkg::DATA_W-1:0]   i_data1,
    input  cache_pkg::way_sel_e            i_lru
);
    import cache_pkg::*;

    cache_state_e     state_q;
    cache_state_e     state_d;
    dc_req_t          cmd_q;
    logic [TAG_W-1:0] tag;
    logic             hit0;
    logic             hit1;
    logic             hit;
    logic             ack;
    logic             fill;
    logic             st_hit;
    way_sel_e         hit_way;

    assign tag     = cmd_q.addr[ADDR_W-1 -: TAG_W];
    assign hit0    = i_vld0 && (i_tag0 == tag);
    assign hit1    = i_vld1 && (i_tag1 == tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1 ? WAY1 : WAY0;
    assign ack     = i_mem_rsp.ack && (state_q == REFILL || state_q == WRITE_MEM);
    assign fill    = i_mem_rsp.ack && (state_q == REFILL);
    assign st_hit  = (state_q == LOOKUP) && cmd_q.we && hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      state_d = i_dc_req ? LOOKUP : IDLE;
            LOOKUP:    state_d = cmd_q.we ? WRITE_MEM : (hit ? RESP : REFILL);
            REFILL:    state_d = ack ? RESP : REFILL;
            WRITE_MEM: state_d = ack ? RESP : WRITE_MEM;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && i_dc_req)
            cmd_q <= i_dc_cmd;
        // load data from a hit or straight from the refill
        if (fill)
            o_dc_rdata <= i_mem_rsp.rdata;
        else if (state_q == LOOKUP && hit && !cmd_q.we)
            o_dc_rdata <= hit1 ? i_data1 : i_data0;
    end

    assign o_dc_busy  = (state_q != IDLE);
    assign o_dc_valid = (state_q == RESP);

    assign o_rd_en = (state_q == IDLE) && i_dc_req;
    assign o_index = (state_q == IDLE) ? i_dc_cmd.addr[3 +: INDEX_W] : cmd_q.addr[3 +: INDEX_W];

    // store hits merge bytes in LOOKUP, store misses leave the arrays alone
    assign o_wr_en   = st_hit || fill;
    assign o_wr_way  = fill ? i_lru : hit_way;
    assign o_wr_tag  = tag;
    assign o_wr_data = fill ? i_mem_rsp.rdata : cmd_q.wdata;
    assign o_wr_strb = fill ? '1 : cmd_q.strb;
    assign o_wr_fill = fill;
    assign o_lru_en  = (state_q == LOOKUP && hit) || fill;
    assign o_lru_way = fill ? i_lru : hit_way;

    assign o_mem_rq = (state_q == REFILL) || (state_q == WRITE_MEM);

    // stores go out as issued, refills read the aligned word
    always_comb begin
        o_mem_req = mem_req_t'(cmd_q);
        if (!cmd_q.we) begin
            o_mem_req.addr[2:0] = 3'b000;
            o_mem_req.strb      = '1;
        end
    end

    a_store_strb: assert property (@(posedge clk) disable iff (!rst)
        i_dc_req && i_dc_cmd.we |-> i_dc_cmd.strb != '0);

endmodule

// ==== icache.sv ====
// instruction cache controller, two-way lookup with refill over the shared memory port
`timescale 1ns/1ps
module icache #(
    parameter int  INDEX_W = 6,
    localparam int TAG_W   = cache_pkg::ADDR_W - INDEX_W - 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_if_req,
    input  logic [cache_pkg::ADDR_W-1:0]   i_if_addr,
    output logic                           o_if_busy,
    output logic                           o_if_valid,
    output logic [31:0]                    o_if_data,
    output cache_pkg::mem_req_t            o_mem_req,
    output logic                           o_mem_rq,
    input  cache_pkg::mem_rsp_t            i_mem_rsp,
    output logic                           o_rd_en,
    output logic [INDEX_W-1:0]             o_index,
    output logic                           o_wr_en,
    output cache_pkg::way_sel_e            o_wr_way,
    output logic [TAG_W-1:0]               o_wr_tag,
    output logic [cache_pkg::DATA_W-1:0]   o_wr_data,
    output logic [cache_pkg::DATA_W/8-1:0] o_wr_strb,
    output logic                           o_wr_fill,
    output logic                           o_lru_en,
    output cache_pkg::way_sel_e            o_lru_way,
    input  logic [TAG_W-1:0]               i_tag0,
    input  logic [TAG_W-1:0]               i_tag1,
    input  logic                           i_vld0,
    input  logic                           i_vld1,
    input  logic [cache_pkg::DATA_W-1:0]   i_data0,
    input  logic [cache_pkg::DATA_W-1:0]   i_data1,
    input  cache_pkg::way_sel_e            i_lru
);
    import cache_pkg::*;

    cache_state_e      state_q;
    cache_state_e      state_d;
    logic [ADDR_W-1:0] addr_q;
    logic [TAG_W-1:0]  tag;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              ack;
    way_sel_e          hit_way;
    logic [DATA_W-1:0] line;

    assign tag     = addr_q[ADDR_W-1 -: TAG_W];
    assign hit0    = i_vld0 && (i_tag0 == tag);
    assign hit1    = i_vld1 && (i_tag1 == tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1 ? WAY1 : WAY0;
    assign ack     = i_mem_rsp.ack && (state_q == REFILL);
    // refill data answers the fetch directly
    assign line    = ack ? i_mem_rsp.rdata : (hit1 ? i_data1 : i_data0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    state_d = i_if_req ? LOOKUP : IDLE;
            LOOKUP:  state_d = hit ? RESP : REFILL;
            REFILL:  state_d = ack ? RESP : REFILL;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && i_if_req)
            addr_q <= i_if_addr;
        // bit 2 picks the instruction within the line
        if ((state_q == LOOKUP && hit) || ack)
            o_if_data <= addr_q[2] ? line[63:32] : line[31:0];
    end

    assign o_if_busy  = (state_q != IDLE);
    assign o_if_valid = (state_q == RESP);

    // read is issued with the strobe so the compare lands in LOOKUP
    assign o_rd_en = (state_q == IDLE) && i_if_req;
    assign o_index = (state_q == IDLE) ? i_if_addr[3 +: INDEX_W] : addr_q[3 +: INDEX_W];

    assign o_wr_en   = ack;
    assign o_wr_way  = i_lru;
    assign o_wr_tag  = tag;
    assign o_wr_data = i_mem_rsp.rdata;
    assign o_wr_strb = '1;
    assign o_wr_fill = 1'b1;
    assign o_lru_en  = (state_q == LOOKUP && hit) || ack;
    assign o_lru_way = ack ? i_lru : hit_way;

    assign o_mem_rq  = (state_q == REFILL);
    assign o_mem_req = '{addr: {addr_q[ADDR_W-1:3], 3'b000}, we: 1'b0, wdata: '0, strb: '1};

    // core only fetches while the cache is idle
    a_no_req_busy: assert property (@(posedge clk) disable iff (!rst)
        i_if_req |-> !o_if_busy);

endmodule

// ==== mem_arbiter.sv ====
// round-robin arbiter sharing the single memory port between instruction and data cache
`timescale 1ns/1ps
module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ic_rq,
    input  cache_pkg::mem_req_t i_ic_req,
    output cache_pkg::mem_rsp_t o_ic_rsp,
    input  logic                i_dc_rq,
    input  cache_pkg::mem_req_t i_dc_req,
    output cache_pkg::mem_rsp_t o_dc_rsp,
    output logic                o_mem_valid,
    output cache_pkg::mem_req_t o_mem_req,
    input  cache_pkg::mem_rsp_t i_mem_rsp
);
    // bit 0 instruction cache, bit 1 data cache
    logic [1:0] gnt_q;
    logic [1:0] gnt_d;
    // set when the data cache wins a tie
    logic       prio_dc_q;
    logic       prio_dc_d;

    always_comb begin
        gnt_d     = gnt_q;
        prio_dc_d = prio_dc_q;
        if (gnt_q == 2'b00) begin
            if (i_ic_rq && (!i_dc_rq || !prio_dc_q))
                gnt_d = 2'b01;
            else if (i_dc_rq)
                gnt_d = 2'b10;
        end else if (i_mem_rsp.ack) begin
            // hand over to the other cache, the served one still holds rq this cycle
            prio_dc_d = gnt_q[0];
            gnt_d     = gnt_q[0] ? {i_dc_rq, 1'b0} : {1'b0, i_ic_rq};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            gnt_q     <= 2'b00;
            prio_dc_q <= 1'b0;
        end else begin
            gnt_q     <= gnt_d;
            prio_dc_q <= prio_dc_d;
        end
    end

    assign o_mem_valid = |gnt_q;
    assign o_mem_req   = gnt_q[1] ? i_dc_req : i_ic_req;
    assign o_ic_rsp    = '{ack: i_mem_rsp.ack && gnt_q[0], rdata: i_mem_rsp.rdata};
    assign o_dc_rsp    = '{ack: i_mem_rsp.ack && gnt_q[1], rdata: i_mem_rsp.rdata};

    // at most one grant, and only to a cache that still requests
    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(gnt_q) && (!gnt_q[0] || i_ic_rq) && (!gnt_q[1] || i_dc_rq));

    // caches hold their request until acked
    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        o_mem_valid && !i_mem_rsp.ack |=> o_mem_valid && $stable(o_mem_req));

endmodule

// ==== tb_cache_subsys.sv ====
// testbench for the cache front end, random fetches, loads and stores checked against a reference model
`timescale 1ns/1ps
module tb_cache_subsys;
    import cache_pkg::*;

    localparam int INDEX_W = 6;
    localparam int SETS    = 2 ** INDEX_W;
    localparam int TIMEOUT = 200;

    logic              clk;
    logic              rst;
    logic              i_if_req;
    logic [ADDR_W-1:0] i_if_addr;
    logic              o_if_busy;
    logic              o_if_valid;
    logic [31:0]       o_if_data;
    logic              i_dc_req;
    dc_req_t           i_dc_cmd;
    logic              o_dc_busy;
    logic              o_dc_valid;
    logic [DATA_W-1:0] o_dc_rdata;
    logic              o_mem_valid;
    mem_req_t          o_mem_req;
    mem_rsp_t          i_mem_rsp;

    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int ic_reads = 0;
    int dc_reads = 0;
    int dc_writes = 0;
    mem_req_t          wr_q [$];
    // aligned word address of the access in flight, one per cache
    logic [ADDR_W-1:0] ic_line = '0;
    logic [ADDR_W-1:0] dc_line = '0;
    // backing memory and the expected contents, both keyed by word address
    logic [DATA_W-1:0] mem     [logic [ADDR_W-4:0]];
    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-4:0]];
    // reference cache state, index 0 is the instruction cache
    logic [ADDR_W-1:0] m_tag [2][2][SETS];
    bit                m_vld [2][2][SETS];
    bit                m_lru [2][SETS];

    cache_subsys_top #(.INDEX_W(INDEX_W)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] init_word(logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] a;
        a = {addr[ADDR_W-1:3], 3'b000};
        return {a ^ 32'h5a5a_c3c3, a * 32'h9e37_79b9};
    endfunction

    function automatic logic [DATA_W-1:0] ref_word(logic [ADDR_W-1:0] addr);
        if (ref_mem.exists(addr[ADDR_W-1:3]))
            return ref_mem[addr[ADDR_W-1:3]];
        return init_word(addr);
    endfunction

    // lines 0..7 cover four tags in each of sets 0 and 1
    function automatic logic [ADDR_W-1:0] line_addr(logic [ADDR_W-1:0] base, int k);
        return base + (k / 2) * 32'h1000 + (k % 2) * 8;
    endfunction

    // predicts a hit and applies fill and LRU rules, store misses change nothing
    function automatic bit model_lookup(int c, logic [ADDR_W-1:0] addr, bit is_store);
        int                set;
        int                way;
        bit                hit;
        logic [ADDR_W-1:0] tg;
        set = addr[3 +: INDEX_W];
        tg  = addr >> (INDEX_W + 3);
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (m_vld[c][w][set] && m_tag[c][w][set] == tg) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit && !is_store) begin
            way = m_lru[c][set];
            m_tag[c][way][set] = tg;
            m_vld[c][way][set] = 1'b1;
        end
        if (hit || !is_store)
            m_lru[c][set] = (way == 0);
        return hit;
    endfunction

    function automatic dc_req_t random_cmd(bit store);
        dc_req_t c;
        c.addr  = line_addr(32'h0001_0000, $urandom_range(0, 7));
        c.we    = store;
        c.wdata = '0;
        c.strb  = '0;
        if (store) begin
            c.wdata = {$urandom, $urandom};
            c.strb  = 8'($urandom_range(1, 255));
        end
        return c;
    endfunction

    task automatic instr_check(string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic load_check(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic mem_req_check(string name, mem_req_t exp, mem_req_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic flag_check(string name, logic exp, logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic count_check(string name, int exp, int got);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic end_test(string name, int err0);
        tests++;
        $display("%s: %0d errors", name, errors - err0);
    endtask

    // memory model, answers one request at a time after 1 to 6 cycles
    initial begin
        mem_req_t          req;
        mem_req_t          exp_req;
        int                delay;
        logic [DATA_W-1:0] word;
        i_mem_rsp = '0;
        forever begin
            @(negedge clk);
            if (o_mem_valid === 1'b1) begin
                req = o_mem_req;
                if (req.addr < 32'h0001_0000)
                    ic_reads++;
                else if (!req.we)
                    dc_reads++;
                if (!req.we) begin
                    exp_req.addr  = (req.addr < 32'h0001_0000) ? ic_line : dc_line;
                    exp_req.we    = 1'b0;
                    exp_req.wdata = '0;
                    exp_req.strb  = '1;
                    mem_req_check("read o_mem_req", exp_req, req);
                end
                delay = $urandom_range(1, 6);
                repeat (delay - 1) begin
                    @(negedge clk);
                    flag_check("o_mem_valid held until ack", 1'b1, o_mem_valid);
                    mem_req_check("o_mem_req held until ack", req, o_mem_req);
                end
                word = mem.exists(req.addr[ADDR_W-1:3]) ? mem[req.addr[ADDR_W-1:3]]
                                                        : init_word(req.addr);
                if (req.we) begin
                    for (int b = 0; b < DATA_W / 8; b++) begin
                        if (req.strb[b])
                            word[8*b +: 8] = req.wdata[8*b +: 8];
                    end
                    mem[req.addr[ADDR_W-1:3]] = word;
                    wr_q.push_back(req);
                    dc_writes++;
                end
                @(posedge clk);
                #1;
                i_mem_rsp = '{ack: 1'b1, rdata: word};
                @(posedge clk);
                #1;
                i_mem_rsp = '{ack: 1'b0, rdata: '0};
            end
        end
    end

    task automatic fetch_op(input logic [ADDR_W-1:0] addr, output bit hit);
        bit                exp_hit;
        logic [DATA_W-1:0] word;
        int                reads0;
        int                cyc;
        exp_hit = model_lookup(0, addr, 1'b0);
        word    = ref_word(addr);
        reads0  = ic_reads;
        ic_line = {addr[ADDR_W-1:3], 3'b000};
        @(posedge clk);
        #1;
        i_if_req  = 1'b1;
        i_if_addr = addr;
        @(posedge clk);
        #1;
        i_if_req = 1'b0;
        cyc = 1;
        @(negedge clk);
        while (!o_if_valid && cyc < TIMEOUT) begin
            flag_check("o_if_busy", 1'b1, o_if_busy);
            cyc++;
            @(negedge clk);
        end
        hit = (ic_reads == reads0);
        if (!o_if_valid) begin
            errors++;
            $display("fetch from %h got no o_if_valid within %0d cycles", addr, TIMEOUT);
        end else begin
            instr_check("o_if_data", addr[2] ? word[63:32] : word[31:0], o_if_data);
            flag_check("icache hit", exp_hit, hit);
            if (exp_hit)
                count_check("fetch hit latency", 2, cyc);
        end
    endtask

    task automatic data_op(input dc_req_t cmd, output bit hit);
        bit                exp_hit;
        logic [DATA_W-1:0] word;
        int                reads0;
        int                writes0;
        int                cyc;
        exp_hit = model_lookup(1, cmd.addr, cmd.we);
        word    = ref_word(cmd.addr);
        if (cmd.we) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
                if (cmd.strb[b])
                    word[8*b +: 8] = cmd.wdata[8*b +: 8];
            end
            ref_mem[cmd.addr[ADDR_W-1:3]] = word;
        end
        reads0  = dc_reads;
        writes0 = dc_writes;
        dc_line = {cmd.addr[ADDR_W-1:3], 3'b000};
        @(posedge clk);
        #1;
        i_dc_req = 1'b1;
        i_dc_cmd = cmd;
        @(posedge clk);
        #1;
        i_dc_req = 1'b0;
        cyc = 1;
        @(negedge clk);
        while (!o_dc_valid && cyc < TIMEOUT) begin
            flag_check("o_dc_busy", 1'b1, o_dc_busy);
            cyc++;
            @(negedge clk);
        end
        hit = (dc_reads == reads0);
        if (!o_dc_valid) begin
            errors++;
            $display("data access to %h got no o_dc_valid within %0d cycles", cmd.addr, TIMEOUT);
        end else if (cmd.we) begin
            count_check("refills on store", 0, dc_reads - reads0);
            count_check("memory writes per store", 1, dc_writes - writes0);
            if (wr_q.size() > 0)
                mem_req_check("store o_mem_req",
                    '{addr: cmd.addr, we: 1'b1, wdata: cmd.wdata, strb: cmd.strb},
                    wr_q.pop_front());
        end else begin
            load_check("o_dc_rdata", word, o_dc_rdata);
            flag_check("dcache hit", exp_hit, hit);
            if (exp_hit)
                count_check("load hit latency", 2, cyc);
        end
    endtask

    initial begin
        int                err0;
        int                ic0;
        int                dc0;
        bit                hit_i;
        bit                hit_d;
        logic [ADDR_W-1:0] f_addr;
        dc_req_t           cmd;
        logic [ADDR_W-1:0] seq [5];
        bit                seq_hit [5];
        void'($urandom(32'h602dee12));
        rst       = 1'b0;
        i_if_req  = 1'b0;
        i_if_addr = '0;
        i_dc_req  = 1'b0;
        i_dc_cmd  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        err0 = errors;
        @(negedge clk);
        flag_check("o_if_valid", 1'b0, o_if_valid);
        flag_check("o_if_busy", 1'b0, o_if_busy);
        flag_check("o_dc_valid", 1'b0, o_dc_valid);
        flag_check("o_dc_busy", 1'b0, o_dc_busy);
        flag_check("o_mem_valid", 1'b0, o_mem_valid);
        ic0 = ic_reads;
        dc0 = dc_reads;
        fetch_op(line_addr(32'h0, 0), hit_i);
        data_op(random_cmd(1'b0), hit_d);
        count_check("reads for first fetch", 1, ic_reads - ic0);
        count_check("reads for first load", 1, dc_reads - dc0);
        end_test("reset", err0);

        err0 = errors;
        repeat (40) fetch_op(line_addr(32'h0, $urandom_range(0, 7)) + 4 * $urandom_range(0, 1),
                             hit_i);
        end_test("fetch", err0);

        // A B A C B in set 5, untouched so far
        err0 = errors;
        seq     = '{32'h4028, 32'h5028, 32'h4028, 32'h6028, 32'h5028};
        seq_hit = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        foreach (seq[i]) begin
            fetch_op(seq[i], hit_i);
            flag_check("replacement hit", seq_hit[i], hit_i);
        end
        end_test("replacement", err0);

        err0 = errors;
        repeat (60) data_op(random_cmd($urandom_range(0, 1)), hit_d);
        end_test("store", err0);

        err0 = errors;
        repeat (30) begin
            f_addr = line_addr(32'h0, $urandom_range(0, 7)) + 4 * $urandom_range(0, 1);
            cmd    = random_cmd($urandom_range(0, 1));
            fork
                fetch_op(f_addr, hit_i);
                data_op(cmd, hit_d);
            join
        end
        end_test("arbitration", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
